// ==== dv/tb_cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_cpu_top;

  localparam int NUM_RUNS  = 8;
  localparam int MEM_WORDS = 1 << `CPU_ADDR_W;
  localparam int LOG_PAGES = 1 << `MMU_PAGE_IDX_W;
  // runs x instructions x accesses x (walk cycles + handshake cycles)
  localparam int TIMEOUT_CYCLES = NUM_RUNS * 28 * 3 * (12 + 8);

  logic               clka;
  logic               rst;
  logic               mem_req_valid;
  logic               mem_req_write;
  mmu_pkg::addr_t     mem_req_addr;
  cpu_isa_pkg::word_t mem_req_wdata;
  logic               mem_req_ready;
  logic               mem_rsp_valid;
  cpu_isa_pkg::word_t mem_rsp_rdata;
  logic               halted;
  logic               fault;

  integer             seed;
  int                 cycle_count = 0;
  cpu_isa_pkg::word_t mem_img [MEM_WORDS];  // memory behind the DUT ports
  cpu_isa_pkg::word_t ref_mem [MEM_WORDS];  // reference model copy
  int                 page_map [LOG_PAGES];  // physical page or -1 when unmapped
  int                 next_page;
  logic               exp_fault;
  mmu_pkg::addr_t     exp_addr [$];
  logic               exp_write [$];
  cpu_isa_pkg::word_t exp_wdata [$];

  logic               stalled = 1'b0;  // request seen with ready low
  mmu_pkg::addr_t     held_addr;
  logic               held_write;
  cpu_isa_pkg::word_t held_wdata;
  int                 rsp_wait = 0;    // cycles until the response
  cpu_isa_pkg::word_t rsp_data;

  cpu_top UUT (
    .clka          (clka),
    .rst           (rst),
    .mem_req_valid (mem_req_valid),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .mem_req_wdata (mem_req_wdata),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_rdata (mem_rsp_rdata),
    .halted        (halted),
    .fault         (fault)
  );

  initial begin
    clka = 1'b0;
    forever #10 clka = ~clka;
  end

  task automatic stop_with_error();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_addr(input string name, input mmu_pkg::addr_t exp,
                            input mmu_pkg::addr_t act);
    if (act !== exp) begin
      $display("CHECK FAILED time %0t %s expected %h actual %h", $time, name, exp, act);
      stop_with_error();
    end
  endtask

  task automatic check_word(input string name, input cpu_isa_pkg::word_t exp,
                            input cpu_isa_pkg::word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED time %0t %s expected %h actual %h", $time, name, exp, act);
      stop_with_error();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED time %0t %s expected %b actual %b", $time, name, exp, act);
      stop_with_error();
    end
  endtask

  // first touch of a logical page takes the next free physical page
  function automatic logic translate(input mmu_pkg::addr_t la, output mmu_pkg::addr_t pa);
    int lp;
    pa = '0;
    lp = int'(la[`CPU_ADDR_W-1:`MMU_OFFSET_W]);
    if (page_map[lp] < 0) begin
      if (next_page >= `MMU_PHYS_PAGES) return 1'b0;
      page_map[lp] = next_page;
      next_page++;
    end
    pa = mmu_pkg::addr_t'(page_map[lp] * `MMU_PAGE_WORDS + int'(la[`MMU_OFFSET_W-1:0]));
    return 1'b1;
  endfunction

  task automatic expect_access(input mmu_pkg::addr_t la, input logic wr,
                               input cpu_isa_pkg::word_t wd, output logic ok,
                               output mmu_pkg::addr_t pa);
    ok = translate(la, pa);
    if (ok) begin
      exp_addr.push_back(pa);
      exp_write.push_back(wr);
      exp_wdata.push_back(wd);
    end
  endtask

  task automatic predict_run();
    cpu_isa_pkg::word_t regs [`CPU_NUM_REGS];
    mmu_pkg::addr_t     pc;
    mmu_pkg::addr_t     pa;
    cpu_isa_pkg::word_t w1;
    cpu_isa_pkg::word_t w2;
    int                 r;
    logic               ok;
    exp_addr.delete();
    exp_write.delete();
    exp_wdata.delete();
    foreach (regs[i]) regs[i] = '0;
    foreach (page_map[i]) page_map[i] = -1;
    page_map[0] = 0;  // logical page 0 lives in physical page 0 after reset
    next_page = 1;
    pc = mmu_pkg::addr_t'(`CPU_PROGRAM_START);
    forever begin
      expect_access(pc, 1'b0, '0, ok, pa);
      if (!ok) break;
      w1 = ref_mem[pa];
      expect_access(pc + mmu_pkg::addr_t'(1), 1'b0, '0, ok, pa);
      if (!ok) break;
      w2 = ref_mem[pa];
      pc = pc + mmu_pkg::addr_t'(2);
      r  = int'(w1[`CPU_REG_IDX_W-1:0]);
      if (w1[15:8] == cpu_isa_pkg::OP_EXIT) break;
      case (w1[15:8])
        cpu_isa_pkg::OP_JMP:       pc = w2[`CPU_ADDR_W-1:0];
        cpu_isa_pkg::OP_RAM2REG: begin
          expect_access(w2[`CPU_ADDR_W-1:0], 1'b0, '0, ok, pa);
          if (!ok) break;
          regs[r] = ref_mem[pa];
        end
        cpu_isa_pkg::OP_REG2RAM: begin
          expect_access(w2[`CPU_ADDR_W-1:0], 1'b1, regs[r], ok, pa);
          if (!ok) break;
          ref_mem[pa] = regs[r];
        end
        cpu_isa_pkg::OP_NUM2REG:   regs[r] = w2;
        cpu_isa_pkg::OP_REG_PLUS:  regs[r] = regs[r] + w2;
        cpu_isa_pkg::OP_REG_MINUS: regs[r] = regs[r] - w2;
        default: ;  // unknown opcode does nothing
      endcase
    end
    exp_fault = !ok;
  endtask

  function automatic cpu_isa_pkg::word_t data_operand(input logic heavy, input int idx);
    cpu_isa_pkg::word_t op;
    op = cpu_isa_pkg::word_t'($random(seed));
    if (heavy) op[`CPU_ADDR_W-1:`MMU_OFFSET_W] = mmu_pkg::page_idx_t'(1 + idx % 15);
    // page 0 data stays below the program
    if (op[`CPU_ADDR_W-1:`MMU_OFFSET_W] == '0) op[5:3] = 3'b000;
    return op;
  endfunction

  task automatic build_program(input logic heavy);
    int                 n;
    int                 sel;
    int                 tgt;
    int                 base;
    logic [7:0]         opc;
    logic [7:0]         reg_byte;
    cpu_isa_pkg::word_t operand;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem_img[a] = cpu_isa_pkg::word_t'($random(seed));
      ref_mem[a] = mem_img[a];
    end
    n = 20 + int'($unsigned($random(seed)) % 8);
    for (int i = 0; i <= n; i++) begin
      sel = heavy ? 1 + int'($unsigned($random(seed)) % 2) : int'($unsigned($random(seed)) % 8);
      operand  = cpu_isa_pkg::word_t'($random(seed));
      reg_byte = 8'($random(seed));
      case (sel)
        0: begin
          opc = cpu_isa_pkg::OP_JMP;
          tgt = i + 1 + int'($unsigned($random(seed)) % (n - i));  // forward up to the exit
          operand = cpu_isa_pkg::word_t'(`CPU_PROGRAM_START + 2 * tgt);
        end
        1: begin
          opc = cpu_isa_pkg::OP_RAM2REG;
          operand = data_operand(heavy, i);
        end
        2, 3: begin
          opc = cpu_isa_pkg::OP_REG2RAM;
          operand = data_operand(heavy, i);
        end
        4: opc = cpu_isa_pkg::OP_NUM2REG;
        5: opc = cpu_isa_pkg::OP_REG_PLUS;
        6: opc = cpu_isa_pkg::OP_REG_MINUS;
        default: opc = 8'h2a;  // not an opcode
      endcase
      if (i == n) opc = cpu_isa_pkg::OP_EXIT;
      base = `CPU_PROGRAM_START + 2 * i;
      ref_mem[base]     = {opc, reg_byte};
      ref_mem[base + 1] = operand;
      mem_img[base]     = ref_mem[base];
      mem_img[base + 1] = operand;
    end
  endtask

  task automatic accept_request();
    mmu_pkg::addr_t     a_exp;
    logic               w_exp;
    cpu_isa_pkg::word_t d_exp;
    if (exp_addr.size() == 0) begin
      $display("unexpected memory request at time %0t to address %h", $time, mem_req_addr);
      stop_with_error();
    end
    a_exp = exp_addr.pop_front();
    w_exp = exp_write.pop_front();
    d_exp = exp_wdata.pop_front();
    check_addr("mem_req_addr", a_exp, mem_req_addr);
    check_bit("mem_req_write", w_exp, mem_req_write);
    if (w_exp) begin
      check_word("mem_req_wdata", d_exp, mem_req_wdata);
      mem_img[mem_req_addr] = mem_req_wdata;
    end else begin
      rsp_data = mem_img[mem_req_addr];
    end
    rsp_wait = 1 + int'($unsigned($random(seed)) % 3);
  endtask

  // memory model with random ready and a 1 to 3 cycle response
  initial begin
    forever begin
      @(posedge clka);
      #1;
      if (stalled) begin  // not accepted last cycle so the request must hold
        check_bit("mem_req_valid", 1'b1, mem_req_valid);
        check_addr("mem_req_addr", held_addr, mem_req_addr);
        check_bit("mem_req_write", held_write, mem_req_write);
        check_word("mem_req_wdata", held_wdata, mem_req_wdata);
      end
      mem_rsp_valid = 1'b0;
      if (rsp_wait > 0) begin
        rsp_wait--;
        if (rsp_wait == 0) begin
          mem_rsp_valid = 1'b1;
          mem_rsp_rdata = rsp_data;
        end
      end
      mem_req_ready = ($random(seed) & 3) != 0;
      stalled = 1'b0;
      if (mem_req_valid === 1'b1) begin
        if (mem_req_ready) begin
          accept_request();
        end else begin
          stalled    = 1'b1;
          held_addr  = mem_req_addr;
          held_write = mem_req_write;
          held_wdata = mem_req_wdata;
        end
      end
    end
  end

  initial begin
    forever begin
      @(posedge clka);
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("timeout, the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_with_error();
      end
    end
  end

  initial begin
    seed          = 86;
    rst           = 1'b0;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_rdata = '0;
    for (int run = 0; run < NUM_RUNS; run++) begin
      rst = 1'b0;
      @(posedge clka);
      build_program(run >= NUM_RUNS - 2);  // last two runs walk enough pages to fault
      predict_run();
      repeat (2) @(posedge clka);
      #1;
      rst = 1'b1;
      while (halted !== 1'b1) begin
        @(posedge clka);
        #1;
      end
      check_bit("fault", exp_fault, fault);
      repeat (6) begin
        @(posedge clka);
        #1;
        check_bit("mem_req_valid", 1'b0, mem_req_valid);
      end
      check_bit("halted", 1'b1, halted);
      if (exp_addr.size() != 0) begin
        $display("run %0d halted with %0d predicted accesses not issued", run, exp_addr.size());
        stop_with_error();
      end
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+source
source/cpu_isa_pkg.sv
source/mmu_pkg.sv
source/mem_access_if.sv
source/reg_file.sv
source/instr_sequencer.sv
source/page_table_walker.sv
source/cpu_top.sv
dv/tb_cpu_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds tb_cpu_top with verilator, runs it into sim.log and checks for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
    --top-module tb_cpu_top -Mdir obj_dir -o sim_tb_cpu_top; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_cpu_top > sim.log 2>&1
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
fi

if [ "$sim_status" -eq 0 ] && grep -qx "Finished with no errors" sim.log; then
  echo "PASS"
  exit 0
fi

echo "FAIL, see sim.log"
exit 1

// ==== source/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath widths
`define CPU_ADDR_W 10        // logical and physical word address
`define CPU_DATA_W 16        // memory word and register width

// register file
`define CPU_NUM_REGS 32
`define CPU_REG_IDX_W 5      // low bits of the instruction reg byte

// paging
`define MMU_PAGE_WORDS 64
`define MMU_OFFSET_W 6       // log2 of the page size
`define MMU_PAGE_IDX_W 4     // 16 logical pages in a 10-bit address
`define MMU_PHYS_PAGES 12    // fewer than logical pages, so the chain can run out

// first program word, the chain starts with page 0 here
`define CPU_PROGRAM_START 8

`endif

// ==== source/cpu_isa_pkg.sv ====
`include "cpu_defs.svh"

package cpu_isa_pkg;

  typedef logic [`CPU_DATA_W-1:0] word_t;

  typedef enum logic [7:0] {
    OP_JMP       = 8'd1,
    OP_RAM2REG   = 8'd2,
    OP_REG2RAM   = 8'd3,
    OP_NUM2REG   = 8'd4,
    OP_REG_PLUS  = 8'd5,
    OP_REG_MINUS = 8'd6,
    OP_EXIT      = 8'd17
  } opcode_e;

  typedef enum logic [2:0] {FETCH1, FETCH2, DECODE, MEM_WAIT, HALT} seq_state_e;

  // first fetch word gives opcode and reg, second word the operand
  typedef struct packed {
    logic [7:0] opcode;
    logic [7:0] reg_num;
    word_t      operand;
  } instr_t;

endpackage

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
  input  logic               clka,
  input  logic               rst,
  output logic               mem_req_valid,
  output logic               mem_req_write,
  output mmu_pkg::addr_t     mem_req_addr,
  output cpu_isa_pkg::word_t mem_req_wdata,
  input  logic               mem_req_ready,
  input  logic               mem_rsp_valid,
  input  cpu_isa_pkg::word_t mem_rsp_rdata,
  output logic               halted,
  output logic               fault
);

  mem_access_if u_mem_if ();

  logic seq_halted;

  // core stops on exit or on a failed page allocation
  assign halted = seq_halted | fault;

  instr_sequencer u_instr_sequencer (
    .clka   (clka),
    .rst    (rst),
    .mem    (u_mem_if.requester),
    .halted (seq_halted)
  );

  page_table_walker u_page_table_walker (
    .clka          (clka),
    .rst           (rst),
    .mem           (u_mem_if.responder),
    .mem_req_valid (mem_req_valid),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .mem_req_wdata (mem_req_wdata),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_rdata (mem_rsp_rdata),
    .fault         (fault)
  );

endmodule

// ==== source/instr_sequencer.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module instr_sequencer (
  input  logic            clka,
  input  logic            rst,
  mem_access_if.requester mem,
  output logic            halted
);

  cpu_isa_pkg::seq_state_e state;
  cpu_isa_pkg::instr_t     instr;
  cpu_isa_pkg::opcode_e    op;
  mmu_pkg::addr_t          pc;
  logic                    issued;     // request of this step accepted
  logic                    step_done;  // response for this step is here
  logic                    wr_en;
  cpu_isa_pkg::word_t      wr_data;
  cpu_isa_pkg::word_t      rd_data;
  logic [`CPU_REG_IDX_W-1:0] reg_idx;

  assign op        = cpu_isa_pkg::opcode_e'(instr.opcode);
  assign reg_idx   = instr.reg_num[`CPU_REG_IDX_W-1:0];
  assign step_done = issued && mem.rsp_valid;
  assign halted    = (state == cpu_isa_pkg::HALT);

  reg_file u_reg_file (
    .clka    (clka),
    .rst     (rst),
    .rd_idx  (reg_idx),
    .wr_idx  (reg_idx),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .rd_data (rd_data)
  );

  // request fields only depend on registered state, so they hold while waiting
  always_comb begin
    mem.req_valid = 1'b0;
    mem.req_write = 1'b0;
    mem.req_addr  = pc;
    mem.req_wdata = rd_data;
    case (state)
      cpu_isa_pkg::FETCH1,
      cpu_isa_pkg::FETCH2: mem.req_valid = !issued;
      cpu_isa_pkg::MEM_WAIT: begin
        mem.req_valid = !issued;
        mem.req_write = (op == cpu_isa_pkg::OP_REG2RAM);
        mem.req_addr  = instr.operand[`CPU_ADDR_W-1:0];
      end
      default: ;
    endcase
  end

  // register writeback
  always_comb begin
    wr_en   = 1'b0;
    wr_data = instr.operand;
    if (state == cpu_isa_pkg::DECODE) begin
      case (op)
        cpu_isa_pkg::OP_NUM2REG: wr_en = 1'b1;
        cpu_isa_pkg::OP_REG_PLUS: begin
          wr_en   = 1'b1;
          wr_data = rd_data + instr.operand;  // wraps at 16 bits
        end
        cpu_isa_pkg::OP_REG_MINUS: begin
          wr_en   = 1'b1;
          wr_data = rd_data - instr.operand;
        end
        default: ;
      endcase
    end else if (state == cpu_isa_pkg::MEM_WAIT && step_done &&
                 op == cpu_isa_pkg::OP_RAM2REG) begin
      wr_en   = 1'b1;
      wr_data = mem.rsp_rdata;
    end
  end

  always_ff @(posedge clka) begin
    if (state == cpu_isa_pkg::FETCH1 && step_done) begin
      instr.opcode  <= mem.rsp_rdata[15:8];
      instr.reg_num <= mem.rsp_rdata[7:0];
    end
    if (state == cpu_isa_pkg::FETCH2 && step_done) begin
      instr.operand <= mem.rsp_rdata;
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state  <= cpu_isa_pkg::FETCH1;
      pc     <= mmu_pkg::addr_t'(`CPU_PROGRAM_START);
      issued <= 1'b0;
    end else begin
      if (mem.req_valid && mem.req_ready) begin
        issued <= 1'b1;
      end else if (step_done) begin
        issued <= 1'b0;
      end
      case (state)
        cpu_isa_pkg::FETCH1: begin
          if (step_done) begin
            pc    <= pc + 1'b1;
            state <= cpu_isa_pkg::FETCH2;
          end
        end
        cpu_isa_pkg::FETCH2: begin
          if (step_done) begin
            pc    <= pc + 1'b1;
            state <= cpu_isa_pkg::DECODE;
          end
        end
        cpu_isa_pkg::DECODE: begin
          case (op)
            cpu_isa_pkg::OP_JMP: begin
              pc    <= instr.operand[`CPU_ADDR_W-1:0];
              state <= cpu_isa_pkg::FETCH1;
            end
            cpu_isa_pkg::OP_RAM2REG,
            cpu_isa_pkg::OP_REG2RAM: state <= cpu_isa_pkg::MEM_WAIT;
            cpu_isa_pkg::OP_EXIT: state <= cpu_isa_pkg::HALT;
            default: state <= cpu_isa_pkg::FETCH1;  // alu ops and unknown opcodes
          endcase
        end
        cpu_isa_pkg::MEM_WAIT: begin
          if (step_done) state <= cpu_isa_pkg::FETCH1;
        end
        default: ;  // halt is final until reset
      endcase
    end
  end

endmodule

// ==== source/mem_access_if.sv ====
`timescale 1ns/1ps

// one logical memory access at a time, sequencer to walker
interface mem_access_if;

  logic                req_valid;
  logic                req_ready;
  logic                req_write;
  mmu_pkg::addr_t      req_addr;   // logical word address
  cpu_isa_pkg::word_t  req_wdata;
  logic                rsp_valid;  // single pulse per accepted access
  cpu_isa_pkg::word_t  rsp_rdata;

  modport requester (
    output req_valid, req_write, req_addr, req_wdata,
    input  req_ready, rsp_valid, rsp_rdata
  );

  modport responder (
    input  req_valid, req_write, req_addr, req_wdata,
    output req_ready, rsp_valid, rsp_rdata
  );

endinterface

// ==== source/mmu_pkg.sv ====
`include "cpu_defs.svh"

package mmu_pkg;

  typedef enum logic [2:0] {
    IDLE,
    SEARCH,
    ALLOC,
    ISSUE,
    WAIT_RSP,
    FAULT
  } walk_state_e;

  typedef logic [`MMU_PAGE_IDX_W-1:0] page_idx_t;
  typedef logic [`CPU_ADDR_W-1:0] addr_t;

endpackage

// ==== source/page_table_walker.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module page_table_walker (
  input  logic               clka,
  input  logic               rst,
  mem_access_if.responder    mem,
  output logic               mem_req_valid,
  output logic               mem_req_write,
  output mmu_pkg::addr_t     mem_req_addr,
  output cpu_isa_pkg::word_t mem_req_wdata,
  input  logic               mem_req_ready,
  input  logic               mem_rsp_valid,
  input  cpu_isa_pkg::word_t mem_rsp_rdata,
  output logic               fault
);

  mmu_pkg::walk_state_e state;

  // chain table, a page pointing at itself ends the chain
  mmu_pkg::page_idx_t chain    [`MMU_PHYS_PAGES];
  mmu_pkg::page_idx_t log_page [`MMU_PHYS_PAGES];
  logic               used     [`MMU_PHYS_PAGES];
  mmu_pkg::page_idx_t alloc_ptr;   // lowest page that may still be free
  mmu_pkg::page_idx_t last_lpage;  // last translation
  mmu_pkg::page_idx_t last_ppage;

  mmu_pkg::page_idx_t cur;    // chain entry being walked
  mmu_pkg::page_idx_t ppage;  // translated page of the held access

  mmu_pkg::addr_t     req_addr_q;
  logic               req_write_q;
  cpu_isa_pkg::word_t req_wdata_q;
  mmu_pkg::page_idx_t in_lpage;
  mmu_pkg::page_idx_t req_lpage;

  assign in_lpage  = mem.req_addr[`CPU_ADDR_W-1:`MMU_OFFSET_W];
  assign req_lpage = req_addr_q[`CPU_ADDR_W-1:`MMU_OFFSET_W];

  assign mem.req_ready = (state == mmu_pkg::IDLE);
  assign mem.rsp_valid = (state == mmu_pkg::WAIT_RSP) && mem_rsp_valid;
  assign mem.rsp_rdata = mem_rsp_rdata;

  assign mem_req_valid = (state == mmu_pkg::ISSUE);
  assign mem_req_write = req_write_q;
  assign mem_req_wdata = req_wdata_q;
  assign mem_req_addr  = mmu_pkg::addr_t'(ppage) * mmu_pkg::addr_t'(`MMU_PAGE_WORDS)
                       + mmu_pkg::addr_t'(req_addr_q[`MMU_OFFSET_W-1:0]);
  assign fault = (state == mmu_pkg::FAULT);

  always_ff @(posedge clka) begin
    if (mem.req_valid && mem.req_ready) begin
      req_addr_q  <= mem.req_addr;
      req_write_q <= mem.req_write;
      req_wdata_q <= mem.req_wdata;
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state <= mmu_pkg::IDLE;
      for (int i = 0; i < `MMU_PHYS_PAGES; i++) begin
        chain[i]    <= mmu_pkg::page_idx_t'(i);
        log_page[i] <= '0;
        used[i]     <= 1'b0;
      end
      used[0]    <= 1'b1;  // logical page 0 sits in physical page 0
      alloc_ptr  <= mmu_pkg::page_idx_t'(1);
      last_lpage <= '0;
      last_ppage <= '0;
      cur        <= '0;
      ppage      <= '0;
    end else begin
      case (state)
        mmu_pkg::IDLE: begin
          if (mem.req_valid) begin
            if (in_lpage == last_lpage) begin
              ppage <= last_ppage;
              state <= mmu_pkg::ISSUE;
            end else begin
              cur   <= '0;  // walk from the chain head
              state <= mmu_pkg::SEARCH;
            end
          end
        end
        mmu_pkg::SEARCH: begin
          if (log_page[cur] == req_lpage) begin
            ppage      <= cur;
            last_lpage <= req_lpage;
            last_ppage <= cur;
            state      <= mmu_pkg::ISSUE;
          end else if (chain[cur] == cur) begin
            state <= mmu_pkg::ALLOC;  // cur stays as the chain tail
          end else begin
            cur <= chain[cur];
          end
        end
        mmu_pkg::ALLOC: begin
          if (alloc_ptr >= mmu_pkg::page_idx_t'(`MMU_PHYS_PAGES)) begin
            state <= mmu_pkg::FAULT;  // out of physical pages
          end else if (!used[alloc_ptr]) begin
            used[alloc_ptr]     <= 1'b1;
            chain[cur]          <= alloc_ptr;
            chain[alloc_ptr]    <= alloc_ptr;
            log_page[alloc_ptr] <= req_lpage;
            ppage               <= alloc_ptr;
            last_lpage          <= req_lpage;
            last_ppage          <= alloc_ptr;
            alloc_ptr           <= alloc_ptr + 1'b1;
            state               <= mmu_pkg::ISSUE;
          end else begin
            alloc_ptr <= alloc_ptr + 1'b1;
          end
        end
        mmu_pkg::ISSUE: begin
          if (mem_req_ready) state <= mmu_pkg::WAIT_RSP;
        end
        mmu_pkg::WAIT_RSP: begin
          if (mem_rsp_valid) state <= mmu_pkg::IDLE;
        end
        default: ;  // fault holds until reset
      endcase
    end
  end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module reg_file (
  input  logic                      clka,
  input  logic                      rst,
  input  logic [`CPU_REG_IDX_W-1:0] rd_idx,
  input  logic [`CPU_REG_IDX_W-1:0] wr_idx,
  input  logic                      wr_en,
  input  cpu_isa_pkg::word_t        wr_data,
  output cpu_isa_pkg::word_t        rd_data
);

  cpu_isa_pkg::word_t regs [`CPU_NUM_REGS];

  // async read, store data and add operand are ready in decode
  assign rd_data = regs[rd_idx];

  always_ff @(posedge clka) begin
    if (!rst) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

endmodule
